// File: hdl/plca_pkg.sv
`default_nettype none

package plca_pkg;

    // widths.
    localparam int NODE_ID_W  = 8;    // node ids, node count and cur_id.
    localparam int NIBBLE_W   = 4;    // mii data nibble.
    localparam int CMD_W      = 2;    // decoded rx command.
    localparam int APB_ADDR_W = 8;    // apb byte address.

    // indication nibbles, sent with TX_EN low and TX_ER high.
    localparam logic [NIBBLE_W-1:0] BEACON_NIBBLE = 4'b0010;
    localparam logic [NIBBLE_W-1:0] COMMIT_NIBBLE = 4'b0011;

    // receive command codes.
    localparam logic [CMD_W-1:0] CMD_NONE   = 2'd0;
    localparam logic [CMD_W-1:0] CMD_BEACON = 2'd1;
    localparam logic [CMD_W-1:0] CMD_COMMIT = 2'd2;

    // register byte offsets.
    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 8'h00;    // plca_en.
    localparam logic [APB_ADDR_W-1:0] REG_CONFIG = 8'h04;    // local id and node count.
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h08;    // cur_id and overflow.

    // register reset values. enable resets to 0.
    localparam logic [NODE_ID_W-1:0] RST_NODE_COUNT = 8'd8;
    localparam logic [NODE_ID_W-1:0] RST_LOCAL_ID   = 8'd255;    // unassigned follower.

endpackage

`default_nettype wire

// File: hdl/plca_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module plca_apb_regs (
    input  wire                             TX_CLK,
    input  wire                             reset,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [plca_pkg::APB_ADDR_W-1:0]  paddr,
    input  wire [31:0]                      pwdata,
    input  wire [plca_pkg::NODE_ID_W-1:0]   cur_id,
    input  wire                             overflow_set,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic                            plca_en,
    output logic [plca_pkg::NODE_ID_W-1:0]  local_node_id,
    output logic [plca_pkg::NODE_ID_W-1:0]  node_count
);
    import plca_pkg::*;

    logic access;      // access phase.
    logic addr_ok;     // address is in the map.
    logic wr_en;       // completed write.
    logic overflow;    // sticky delay line overflow.

    assign access  = psel && penable;
    assign addr_ok = (paddr == REG_CTRL) || (paddr == REG_CONFIG) || (paddr == REG_STATUS);
    assign wr_en   = access && pwrite && addr_ok;
    assign pready  = 1'b1;                  // zero wait states.
    assign pslverr = access && !addr_ok;    // unlisted address.

    // read word mux.
    always_comb
    begin
        case (paddr)
            REG_CTRL:   prdata = {31'd0, plca_en};
            REG_CONFIG: prdata = {{(32 - 2 * NODE_ID_W){1'b0}}, node_count, local_node_id};
            REG_STATUS: prdata = {{(31 - NODE_ID_W){1'b0}}, overflow, cur_id};
            default:    prdata = 32'd0;
        endcase
    end

    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            plca_en       <= 1'b0;
            local_node_id <= RST_LOCAL_ID;
            node_count    <= RST_NODE_COUNT;
            overflow      <= 1'b0;
        end
        else
        begin
            if (wr_en && paddr == REG_CTRL)
            begin
                plca_en <= pwdata[0];
            end
            if (wr_en && paddr == REG_CONFIG)
            begin
                local_node_id <= pwdata[NODE_ID_W-1:0];
                node_count    <= pwdata[2*NODE_ID_W-1:NODE_ID_W];
            end
            if (overflow_set)
            begin
                overflow <= 1'b1;    // a new drop wins over the clear.
            end
            else if (wr_en && paddr == REG_STATUS && pwdata[8])
            begin
                overflow <= 1'b0;    // write 1 to clear.
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/plca_rx_decode.sv
`timescale 1ns/1ps
`default_nettype none

module plca_rx_decode (
    input  wire                            TX_CLK,
    input  wire                            reset,
    input  wire [plca_pkg::NIBBLE_W-1:0]   RXD,
    input  wire                            RX_DV,
    input  wire                            RX_ER,
    output logic [plca_pkg::CMD_W-1:0]     rx_cmd,
    output logic                           receiving
);
    import plca_pkg::*;

    logic [CMD_W-1:0] cmd_next;    // decode of the current sample.

    // indications only exist with RX_DV low and RX_ER high.
    always_comb
    begin
        cmd_next = CMD_NONE;
        if (!RX_DV && RX_ER)
        begin
            case (RXD)
                BEACON_NIBBLE: cmd_next = CMD_BEACON;
                COMMIT_NIBBLE: cmd_next = CMD_COMMIT;
                default:       cmd_next = CMD_NONE;    // reserved codes.
            endcase
        end
    end

    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            rx_cmd    <= CMD_NONE;
            receiving <= 1'b0;
        end
        else
        begin
            rx_cmd    <= cmd_next;
            receiving <= RX_DV || (cmd_next == CMD_COMMIT);    // data or held commit.
        end
    end

endmodule

`default_nettype wire

// File: hdl/plca_to_timer.sv
`timescale 1ns/1ps
`default_nettype none

module plca_to_timer #(
    parameter int beacon_cycles = 5,
    parameter int to_cycles     = 8
) (
    input  wire  TX_CLK,
    input  wire  reset,
    input  wire  timer_start_beacon,
    input  wire  timer_start_to,
    output logic timer_done
);
    // counter sized for the longer of the two intervals.
    localparam int max_cycles = (beacon_cycles > to_cycles) ? beacon_cycles : to_cycles;
    localparam int cnt_w      = $clog2(max_cycles + 1);

    logic [cnt_w-1:0] count;     // cycles left before done.
    logic             active;    // an interval is running.

    // done shows in the cycle the count reaches zero.
    assign timer_done = active && (count == '0);

    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            count  <= '0;
            active <= 1'b0;
        end
        else if (timer_start_beacon)
        begin
            count  <= cnt_w'(beacon_cycles - 1);    // done lands beacon_cycles later.
            active <= 1'b1;
        end
        else if (timer_start_to)
        begin
            count  <= cnt_w'(to_cycles - 1);
            active <= 1'b1;
        end
        else if (active)
        begin
            if (count == '0)
            begin
                active <= 1'b0;    // single done pulse.
            end
            else
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/plca_control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module plca_control_fsm (
    input  wire                             TX_CLK,
    input  wire                             reset,
    input  wire                             plca_en,
    input  wire [plca_pkg::NODE_ID_W-1:0]   local_node_id,
    input  wire [plca_pkg::NODE_ID_W-1:0]   node_count,
    input  wire [plca_pkg::CMD_W-1:0]       rx_cmd,
    input  wire                             receiving,
    input  wire                             timer_done,
    input  wire                             packet_pending,
    input  wire                             tx_done,
    output logic                            timer_start_beacon,
    output logic                            timer_start_to,
    output logic                            send_beacon,
    output logic                            send_commit,
    output logic                            transmit,
    output logic [plca_pkg::NODE_ID_W-1:0]  cur_id
);
    import plca_pkg::*;

    localparam logic [3:0] DISABLE     = 4'd0;
    localparam logic [3:0] RESYNC      = 4'd1;
    localparam logic [3:0] SEND_BEACON = 4'd2;
    localparam logic [3:0] SYNCING     = 4'd3;
    localparam logic [3:0] WAIT_TO     = 4'd4;
    localparam logic [3:0] RECEIVE     = 4'd5;
    localparam logic [3:0] COMMIT      = 4'd6;
    localparam logic [3:0] TRANSMIT    = 4'd7;
    localparam logic [3:0] NEXT_TX_OP  = 4'd8;

    logic [3:0]         state;
    logic [3:0]         next_state;
    logic [NODE_ID_W:0] next_id;        // one wider so 255 + 1 does not wrap.
    logic               coordinator;    // node 0 owns the beacon.
    logic               clear_id;
    logic               step_id;

    assign coordinator = (local_node_id == '0);
    assign next_id     = cur_id + 1'b1;

    assign send_beacon = (state == SEND_BEACON);
    assign send_commit = (state == COMMIT);    // exactly one cycle.
    assign transmit    = (state == TRANSMIT);

    // timer starts are issued on the transition into a timed state.
    always_comb
    begin
        next_state         = state;
        timer_start_beacon = 1'b0;
        timer_start_to     = 1'b0;
        clear_id           = 1'b0;
        step_id            = 1'b0;
        if (!plca_en)
        begin
            next_state = DISABLE;
        end
        else if (!coordinator && rx_cmd == CMD_BEACON && state != TRANSMIT)
        begin
            next_state = SYNCING;    // follower locks to any beacon.
        end
        else
        begin
            case (state)
                DISABLE:
                begin
                    if (coordinator)
                    begin
                        next_state         = SEND_BEACON;
                        timer_start_beacon = 1'b1;
                    end
                    else
                    begin
                        next_state = RESYNC;
                    end
                end
                RESYNC: next_state = RESYNC;    // left only by a received beacon.
                SEND_BEACON:
                begin
                    if (timer_done)
                    begin
                        next_state     = WAIT_TO;    // coordinator starts slot 0 at once.
                        timer_start_to = 1'b1;
                        clear_id       = 1'b1;
                    end
                end
                SYNCING:
                begin
                    next_state     = WAIT_TO;    // beacon has ended here.
                    timer_start_to = 1'b1;
                    clear_id       = 1'b1;
                end
                WAIT_TO:
                begin
                    if (cur_id == local_node_id && packet_pending)
                    begin
                        next_state = COMMIT;
                    end
                    else if (receiving)
                    begin
                        next_state = RECEIVE;    // another node took the slot.
                    end
                    else if (timer_done)
                    begin
                        next_state = NEXT_TX_OP;
                    end
                end
                RECEIVE:
                begin
                    if (!receiving)
                    begin
                        next_state = NEXT_TX_OP;
                    end
                end
                COMMIT: next_state = TRANSMIT;
                TRANSMIT:
                begin
                    if (tx_done)
                    begin
                        next_state = NEXT_TX_OP;
                    end
                end
                NEXT_TX_OP:
                begin
                    if (coordinator && next_id >= node_count)
                    begin
                        next_state         = SEND_BEACON;    // cycle complete.
                        timer_start_beacon = 1'b1;
                        clear_id           = 1'b1;
                    end
                    else
                    begin
                        next_state     = WAIT_TO;
                        timer_start_to = 1'b1;
                        step_id        = 1'b1;
                    end
                end
                default: next_state = DISABLE;
            endcase
        end
    end

    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            state  <= DISABLE;
            cur_id <= '0;
        end
        else
        begin
            state <= next_state;
            if (!plca_en || clear_id)
            begin
                cur_id <= '0;
            end
            else if (step_id)
            begin
                cur_id <= next_id[NODE_ID_W-1:0];    // follower wraps freely.
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/plca_tx_data.sv
`timescale 1ns/1ps
`default_nettype none

module plca_tx_data #(
    parameter int delay_depth = 32
) (
    input  wire                            TX_CLK,
    input  wire                            reset,
    input  wire [plca_pkg::NIBBLE_W-1:0]   mac_txd,
    input  wire                            mac_tx_en,
    input  wire                            mac_tx_er,
    input  wire                            send_beacon,
    input  wire                            send_commit,
    input  wire                            transmit,
    output logic                           packet_pending,
    output logic                           tx_done,
    output logic                           overflow_set,
    output logic                           mac_crs,
    output logic [plca_pkg::NIBBLE_W-1:0]  TXD,
    output logic                           TX_EN,
    output logic                           TX_ER
);
    import plca_pkg::*;

    localparam int ptr_w = (delay_depth > 1) ? $clog2(delay_depth) : 1;
    localparam int cnt_w = $clog2(delay_depth + 1);

    logic [NIBBLE_W:0]  line_mem [delay_depth];    // {er, nibble}.
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   fill;                      // nibbles held.
    logic               wr_en;
    logic               rd_en;
    logic [NIBBLE_W:0]  rd_word;

    assign wr_en        = mac_tx_en && (fill != cnt_w'(delay_depth));
    assign rd_en        = transmit && (fill != '0);
    assign overflow_set = mac_tx_en && (fill == cnt_w'(delay_depth));    // nibble dropped.
    assign tx_done      = transmit && (fill == '0) && !mac_tx_en;       // line drained.
    assign rd_word      = line_mem[rd_ptr];

    always_ff @(posedge TX_CLK)
    begin
        if (wr_en)
        begin
            line_mem[wr_ptr] <= {mac_tx_er, mac_txd};
        end
    end

    // circular pointers and frame bookkeeping.
    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fill           <= '0;
            packet_pending <= 1'b0;
            mac_crs        <= 1'b0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == ptr_w'(delay_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= (rd_ptr == ptr_w'(delay_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + cnt_w'(wr_en) - cnt_w'(rd_en);
            if (tx_done)
            begin
                packet_pending <= 1'b0;
            end
            else if (wr_en)
            begin
                packet_pending <= 1'b1;    // from the first stored nibble.
            end
            mac_crs <= packet_pending || wr_en;    // drops one cycle after TX_EN.
        end
    end

    // mii transmit mux, registered.
    always_ff @(posedge TX_CLK)
    begin
        if (reset)
        begin
            TXD   <= '0;
            TX_EN <= 1'b0;
            TX_ER <= 1'b0;
        end
        else if (send_beacon)
        begin
            TXD   <= BEACON_NIBBLE;
            TX_EN <= 1'b0;
            TX_ER <= 1'b1;
        end
        else if (send_commit)
        begin
            TXD   <= COMMIT_NIBBLE;
            TX_EN <= 1'b0;
            TX_ER <= 1'b1;
        end
        else if (rd_en)
        begin
            TXD   <= rd_word[NIBBLE_W-1:0];    // replayed frame.
            TX_EN <= 1'b1;
            TX_ER <= rd_word[NIBBLE_W];
        end
        else
        begin
            TXD   <= '0;    // idle.
            TX_EN <= 1'b0;
            TX_ER <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/plca_rs.sv
`timescale 1ns/1ps
`default_nettype none

module plca_rs #(
    parameter int beacon_cycles = 5,     // beacon length in cycles.
    parameter int to_cycles     = 8,     // empty opportunity wait.
    parameter int delay_depth   = 32     // delay line nibbles.
) (
    input  wire                             TX_CLK,
    input  wire                             reset,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [plca_pkg::APB_ADDR_W-1:0]  paddr,
    input  wire [31:0]                      pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  wire [plca_pkg::NIBBLE_W-1:0]    mac_txd,
    input  wire                             mac_tx_en,
    input  wire                             mac_tx_er,
    output logic                            mac_crs,
    input  wire [plca_pkg::NIBBLE_W-1:0]    RXD,
    input  wire                             RX_DV,
    input  wire                             RX_ER,
    output logic [plca_pkg::NIBBLE_W-1:0]   TXD,
    output logic                            TX_EN,
    output logic                            TX_ER
);
    import plca_pkg::*;

    // configuration and status.
    logic                 plca_en;
    logic [NODE_ID_W-1:0] local_node_id;
    logic [NODE_ID_W-1:0] node_count;
    logic [NODE_ID_W-1:0] cur_id;
    logic                 overflow_set;

    // receive indications.
    logic [CMD_W-1:0]     rx_cmd;
    logic                 receiving;

    // fsm handshakes.
    logic                 timer_start_beacon;
    logic                 timer_start_to;
    logic                 timer_done;
    logic                 send_beacon;
    logic                 send_commit;
    logic                 transmit;
    logic                 packet_pending;
    logic                 tx_done;

    plca_apb_regs apb_regs_i (.*);

    plca_rx_decode rx_decode_i (.*);

    plca_to_timer #(
        .beacon_cycles (beacon_cycles),
        .to_cycles     (to_cycles)
    ) to_timer_i (.*);

    plca_control_fsm control_fsm_i (.*);

    plca_tx_data #(
        .delay_depth (delay_depth)
    ) tx_data_i (.*);

endmodule

`default_nettype wire

// File: tests/plca_rs_sva.sv
`timescale 1ns/1ps
`default_nettype none

module plca_rs_sva #(
    parameter int beacon_cycles = 5
) (
    input wire                           TX_CLK,
    input wire                           reset,
    input wire [plca_pkg::NIBBLE_W-1:0]  TXD,
    input wire                           TX_EN,
    input wire                           TX_ER
);
    import plca_pkg::*;

    logic beacon_code;    // BEACON indication on the line.

    assign beacon_code = !TX_EN && TX_ER && (TXD == BEACON_NIBBLE);

    // mii transmit comes out of reset idle.
    assert property (@(posedge TX_CLK) reset |=> !TX_EN)
        else $error("TX_EN high after a reset cycle");

    assert property (@(posedge TX_CLK) disable iff (reset)
                     !(TX_EN && TX_ER && TXD == BEACON_NIBBLE))
        else $error("TX_EN high together with the BEACON code");

    // full beacon, never cut or stretched.
    assert property (@(posedge TX_CLK) disable iff (reset)
                     $rose(beacon_code) |-> beacon_code [*beacon_cycles] ##1 !beacon_code)
        else $error("BEACON length differs from beacon_cycles");

endmodule

bind plca_rs plca_rs_sva #(.beacon_cycles(beacon_cycles)) sva_i (.*);

`default_nettype wire

// File: tests/plca_rs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module plca_rs_tb;
    import plca_pkg::*;

    localparam int beacon_cycles   = 5;
    localparam int to_cycles       = 8;
    localparam int delay_depth     = 32;
    localparam int beacon_period   = beacon_cycles + 4 * (to_cycles + 1);    // node_count 4.
    localparam int watchdog_cycles = 12 * beacon_period * 3;    // about 12 periods of tests.

    logic                  TX_CLK;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic [NIBBLE_W-1:0]   mac_txd;
    logic                  mac_tx_en;
    logic                  mac_tx_er;
    logic                  mac_crs;
    logic [NIBBLE_W-1:0]   RXD;
    logic                  RX_DV;
    logic                  RX_ER;
    logic [NIBBLE_W-1:0]   TXD;
    logic                  TX_EN;
    logic                  TX_ER;
    logic [NIBBLE_W-1:0]   sent_q [$];    // nibbles given to the mac port.
    logic [7:0]            lfsr_state;

    plca_rs #(
        .beacon_cycles (beacon_cycles),
        .to_cycles     (to_cycles),
        .delay_depth   (delay_depth)
    ) dut_i (.*);

    initial TX_CLK = 1'b0;
    always #50 TX_CLK = ~TX_CLK;    // 100 ns period.

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_nibble(input logic [NIBBLE_W-1:0] got,
                                  input logic [NIBBLE_W-1:0] exp, input string msg);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp));
    endtask

    task automatic compare_id(input logic [NODE_ID_W-1:0] got,
                              input logic [NODE_ID_W-1:0] exp, input string msg);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t ns: %s, got %0d, expected %0d",
                               $time, msg, got, exp));
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string msg);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t ns: %s, got %b, expected %b", $time, msg, got, exp));
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp));
    endtask

    // taps 8, 6, 5, 4.
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge TX_CLK);
        #10;
        psel    = 1'b1;    // setup phase.
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge TX_CLK);
        #10;
        penable = 1'b1;    // access phase.
        @(negedge TX_CLK);
        compare_bit(pready, 1'b1, "pready in the access phase");
        compare_bit(pslverr, 1'b0, "pslverr on a write");
        @(posedge TX_CLK);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge TX_CLK);
        #10;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge TX_CLK);
        #10;
        penable = 1'b1;
        @(negedge TX_CLK);
        compare_bit(pready, 1'b1, "pready in the access phase");
        data = prdata;
        err  = pslverr;
        @(posedge TX_CLK);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic mac_send_frame(input int len);
        logic [NIBBLE_W-1:0] nib;
        int                  i;
        int                  b;
        sent_q.delete();
        for (i = 0; i < len; i++)
        begin
            for (b = 0; b < NIBBLE_W; b++)
            begin
                lfsr_state = lfsr_step(lfsr_state);    // one step per bit taken.
                nib[b]     = lfsr_state[0];
            end
            @(posedge TX_CLK);
            #10;
            mac_txd   = nib;
            mac_tx_en = 1'b1;
            sent_q.push_back(nib);
        end
        @(posedge TX_CLK);
        #10;
        mac_tx_en = 1'b0;
        mac_txd   = '0;
    endtask

    task automatic rx_send_beacon();
        @(posedge TX_CLK);
        #10;
        RX_ER = 1'b1;    // indication, RX_DV stays low.
        RXD   = BEACON_NIBBLE;
        repeat (beacon_cycles) @(posedge TX_CLK);
        #10;
        RX_ER = 1'b0;
        RXD   = '0;
    endtask

    // another node's frame; our TX must stay silent meanwhile.
    task automatic rx_send_frame(input int len);
        int i;
        for (i = 0; i < len; i++)
        begin
            @(posedge TX_CLK);
            #10;
            RX_DV = 1'b1;
            RXD   = NIBBLE_W'(i);
            @(negedge TX_CLK);
            compare_bit(TX_EN, 1'b0, "TX_EN while another node sends");
            compare_bit(TX_ER, 1'b0, "TX_ER while another node sends");
        end
        @(posedge TX_CLK);
        #10;
        RX_DV = 1'b0;
        RXD   = '0;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge TX_CLK);
            compare_bit(TX_EN, 1'b0, "idle TX_EN");
            compare_bit(TX_ER, 1'b0, "idle TX_ER");
            compare_nibble(TXD, '0, "idle TXD");
        end
    endtask

    task automatic poll_cur_id(input logic [NODE_ID_W-1:0] id, input int max_reads);
        logic [31:0] rd;
        logic        err;
        int          n;
        n = 0;
        apb_read(REG_STATUS, rd, err);
        while (rd[NODE_ID_W-1:0] != id)
        begin
            n++;
            if (n > max_reads)
                stop_run($sformatf("status cur_id never reached %0d", id));
            apb_read(REG_STATUS, rd, err);
        end
    endtask

    // measures length and start spacing of the next few beacons on TX.
    task automatic check_beacons(input int count);
        int t;
        int run;
        int seen;
        int last_start;
        bit prev;
        bit now;
        t          = 0;
        run        = 0;
        seen       = 0;
        last_start = -1;
        prev       = 1'b0;
        while (seen < count || prev)
        begin
            @(negedge TX_CLK);
            now = !TX_EN && TX_ER && (TXD == BEACON_NIBBLE);
            if (now && !prev)
            begin
                if (last_start >= 0)
                    compare_word(32'(t - last_start), 32'(beacon_period), "beacon start spacing");
                last_start = t;
                seen++;
                run = 0;
            end
            if (now)
                run++;
            if (!now && prev)
                compare_word(32'(run), 32'(beacon_cycles), "beacon length");
            prev = now;
            t++;
            if (t > (count + 1) * beacon_period)
                stop_run("timed out waiting for regular beacons on TX");
        end
    endtask

    // one COMMIT cycle, then sent_q back to back with TX_EN high.
    task automatic expect_replay(input int max_wait);
        int waited;
        int i;
        waited = 0;
        @(negedge TX_CLK);
        while (!(!TX_EN && TX_ER && TXD == COMMIT_NIBBLE))
        begin
            compare_bit(TX_EN, 1'b0, "TX_EN before COMMIT");
            waited++;
            if (waited > max_wait)
                stop_run("timed out waiting for COMMIT on TX");
            @(negedge TX_CLK);
        end
        for (i = 0; i < sent_q.size(); i++)
        begin
            @(negedge TX_CLK);
            compare_bit(TX_EN, 1'b1, "TX_EN during replay");
            compare_bit(TX_ER, 1'b0, "TX_ER during replay");
            compare_nibble(TXD, sent_q[i], $sformatf("replayed nibble %0d", i));
            compare_bit(mac_crs, 1'b1, "mac_crs during replay");
        end
        @(negedge TX_CLK);
        compare_bit(TX_EN, 1'b0, "TX_EN after the last nibble");
        waited = 0;
        while (mac_crs)
        begin
            waited++;
            if (waited > 4)
                stop_run("mac_crs stayed high after the replay ended");
            @(negedge TX_CLK);
        end
    endtask

    task automatic check_id_in_replay(input logic [NODE_ID_W-1:0] id);
        logic [31:0] rd;
        logic        err;
        int          waited;
        waited = 0;
        @(negedge TX_CLK);
        while (!TX_EN)
        begin
            waited++;
            if (waited > 2 * beacon_period)
                stop_run("timed out waiting for TX_EN");
            @(negedge TX_CLK);
        end
        apb_read(REG_STATUS, rd, err);
        compare_id(rd[NODE_ID_W-1:0], id, "status cur_id during replay");
        compare_bit(TX_EN, 1'b1, "TX_EN still high after the status read");
    endtask

    task automatic test_registers();
        logic [31:0] rd;
        logic        err;
        @(negedge TX_CLK);
        compare_bit(TX_EN, 1'b0, "TX_EN after reset");
        compare_bit(TX_ER, 1'b0, "TX_ER after reset");
        compare_nibble(TXD, '0, "TXD after reset");
        compare_bit(mac_crs, 1'b0, "mac_crs after reset");
        compare_bit(pslverr, 1'b0, "pslverr after reset");
        apb_read(REG_CTRL, rd, err);
        compare_word(rd, 32'h0000_0000, "ctrl reset value");
        apb_read(REG_CONFIG, rd, err);
        compare_word(rd, 32'h0000_08ff, "config reset value");    // count 8, id 255.
        apb_read(REG_STATUS, rd, err);
        compare_word(rd, 32'h0000_0000, "status reset value");
        compare_bit(err, 1'b0, "pslverr on status read");
        apb_read(8'h0c, rd, err);
        compare_bit(err, 1'b1, "pslverr on an unlisted address");
        apb_write(REG_CONFIG, 32'h0000_0403);
        apb_read(REG_CONFIG, rd, err);
        compare_word(rd, 32'h0000_0403, "config read back");
        apb_write(REG_CTRL, 32'h1);
        apb_read(REG_CTRL, rd, err);
        compare_word(rd, 32'h1, "ctrl read back");
        apb_write(REG_CTRL, 32'h0);
        apb_read(REG_CTRL, rd, err);
        compare_word(rd, 32'h0, "ctrl cleared");
        apb_write(REG_CONFIG, 32'h0000_0400);    // coordinator id, still disabled.
        check_idle(12);
    endtask

    task automatic test_coordinator_beacon();
        logic [31:0] rd;
        logic        err;
        apb_write(REG_CONFIG, 32'h0000_0400);    // count 4, id 0.
        apb_write(REG_CTRL, 32'h1);
        check_beacons(3);
        repeat (6)
        begin
            apb_read(REG_STATUS, rd, err);
            compare_bit(rd[NODE_ID_W-1:0] < 8'd4, 1'b1, "cur_id below node_count");
        end
    endtask

    task automatic test_coordinator_transmit();
        poll_cur_id(8'd1, 40);    // out of slot 0.
        mac_send_frame(16);
        @(negedge TX_CLK);
        compare_bit(mac_crs, 1'b1, "mac_crs with a frame pending");
        expect_replay(2 * beacon_period);
    endtask

    task automatic test_follower();
        // replay just ended in slot 0, so no beacon is cut here.
        apb_write(REG_CTRL, 32'h0);
        apb_write(REG_CONFIG, 32'h0000_0402);    // count 4, id 2.
        apb_write(REG_CTRL, 32'h1);
        mac_send_frame(12);
        @(negedge TX_CLK);
        compare_bit(mac_crs, 1'b1, "mac_crs with a frame pending");
        check_idle(4 * (to_cycles + 1));    // not synced yet.
        rx_send_beacon();
        poll_cur_id(8'd1, 20);
        rx_send_frame(10);
        fork
            expect_replay(2 * beacon_period);
            check_id_in_replay(8'd2);
        join
    endtask

    task automatic test_overflow();
        logic [31:0] rd;
        logic        err;
        apb_write(REG_CTRL, 32'h0);    // frame stays pending.
        apb_read(REG_STATUS, rd, err);
        compare_bit(rd[8], 1'b0, "overflow before the long frame");
        mac_send_frame(delay_depth + 4);
        apb_read(REG_STATUS, rd, err);
        compare_bit(rd[8], 1'b1, "overflow after the long frame");
        apb_write(REG_STATUS, 32'h0000_0100);
        apb_read(REG_STATUS, rd, err);
        compare_bit(rd[8], 1'b0, "overflow after write 1 to clear");
    endtask

    initial
    begin
        lfsr_state  = 8'd85;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        mac_txd     = '0;
        mac_tx_en   = 1'b0;
        mac_tx_er   = 1'b0;
        RXD         = '0;
        RX_DV       = 1'b0;
        RX_ER       = 1'b0;
        repeat (8) @(posedge TX_CLK);
        #10;
        reset = 1'b0;
        test_registers();
        test_coordinator_beacon();
        test_coordinator_transmit();
        test_follower();
        test_overflow();
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge TX_CLK);
        stop_run("watchdog expired, the tests did not finish in time");
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/plca_pkg.sv
hdl/plca_apb_regs.sv
hdl/plca_rx_decode.sv
hdl/plca_to_timer.sv
hdl/plca_control_fsm.sv
hdl/plca_tx_data.sv
hdl/plca_rs.sv
tests/plca_rs_sva.sv
tests/plca_rs_tb.sv
